/* verilog.f */
rtl/matrix_alu_pkg.sv
rtl/alu_req_if.sv
rtl/alu_seq_ctrl.sv
rtl/elem_datapath.sv
rtl/matrix_alu_top.sv
verif/matrix_alu_asserts.sv
verif/matrix_alu_tb.sv

/* Bender.yml */
package:
  name: matrix_alu

sources:
  # Design, in compile order
  - files:
      - rtl/matrix_alu_pkg.sv
      - rtl/alu_req_if.sv
      - rtl/alu_seq_ctrl.sv
      - rtl/elem_datapath.sv
      - rtl/matrix_alu_top.sv

  # Verification
  - target: test
    files:
      - verif/matrix_alu_asserts.sv
      - verif/matrix_alu_tb.sv

/* verif/matrix_alu_tb.sv */
/* Matrix ALU testbench
   Random jobs from an LFSR, checked against a reference model under back-pressure */

`timescale 1ns/10ps
`default_nettype none

module matrix_alu_tb;
  import matrix_alu_pkg::*;

  localparam int OPS_PER_TEST = 12;
  localparam int OP_TIMEOUT   = 2000;

  logic        clk;
  logic        rst_n;
  logic        start_i;
  op_code_t    op_i;
  mat_flat_t   mat_a_i;
  mat_flat_t   mat_b_i;
  dim_t        a_rows_i;
  dim_t        a_cols_i;
  dim_t        b_rows_i;
  dim_t        b_cols_i;
  elem_t       scalar_i;
  logic        stream_ready_i;
  logic        done_o;
  logic        error_o;
  cnt_t        cycle_cnt_o;
  logic        stream_valid_o;
  acc_t        stream_data_o;
  logic        stream_last_col_o;

  logic [15:0] lfsr_q;
  // Random stream_ready_i when set
  logic        bp_en;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;

  // Model copies of the operands
  int          a_m [MAX_DIM][MAX_DIM];
  int          b_m [MAX_DIM][MAX_DIM];
  // Expected beats in row-major order
  acc_t        exp_q [$];
  logic        exp_last_q [$];

  matrix_alu_top matrix_alu_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // Random source
  // ------------------------------
  // Taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Legal dimension 1..4
  function automatic dim_t rand_dim();
    return dim_t'(rand_bits(2) + 32'd1);
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic load_operands();
    elem_t e;
    for (int r = 0; r < MAX_DIM; r++) begin
      for (int c = 0; c < MAX_DIM; c++) begin
        e         = elem_t'(rand_bits(ELEM_W));
        a_m[r][c] = int'(e);
        mat_a_i[(r*MAX_DIM+c)*ELEM_W +: ELEM_W] = e;
        e         = elem_t'(rand_bits(ELEM_W));
        b_m[r][c] = int'(e);
        mat_b_i[(r*MAX_DIM+c)*ELEM_W +: ELEM_W] = e;
      end
    end
  endtask

  task automatic build_expected(input op_code_t op, input dim_t ar, input dim_t ac,
                                input dim_t bc, input elem_t s);
    int rows;
    int cols;
    int v;
    exp_q.delete();
    exp_last_q.delete();
    rows = int'(ar);
    cols = int'(ac);
    if (op == OP_TRANSPOSE) begin
      rows = int'(ac);
      cols = int'(ar);
    end else if (op == OP_MAT_MUL) begin
      cols = int'(bc);
    end
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        case (op)
          OP_ADD:        v = a_m[r][c] + b_m[r][c];
          OP_SCALAR_MUL: v = a_m[r][c] * int'(s);
          OP_TRANSPOSE:  v = a_m[c][r];
          default: begin
            // Full-precision inner product
            v = 0;
            for (int k = 0; k < int'(ac); k++) begin
              v = v + a_m[r][k] * b_m[k][c];
            end
          end
        endcase
        exp_q.push_back(acc_t'(v));
        exp_last_q.push_back(c == cols - 1);
      end
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_elem(input acc_t got, input acc_t exp, input logic got_last,
                            input logic exp_last);
    chk_cnt++;
    if ((got !== exp) || (got_last !== exp_last)) begin
      err_cnt++;
      $display("Mismatch at %0t: beat %0d last_col %0b, expected %0d last_col %0b",
               $time, got, got_last, exp, exp_last);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input cnt_t got, input cnt_t min_val);
    chk_cnt++;
    if (got < min_val) begin
      err_cnt++;
      $display("Mismatch at %0t: %s is %0d, expected at least %0d", $time, what, got, min_val);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Some tests failed");
    $finish;
  endtask

  // ------------------------------
  // One job, start to done
  // ------------------------------
  task automatic run_op(input op_code_t op, input dim_t ar, input dim_t ac, input dim_t br,
                        input dim_t bc, input logic exp_err);
    int          cycles;
    int          exp_beats;
    logic        seen_done;
    logic [31:0] r;
    // Previous done must have dropped
    cycles = 0;
    while (done_o && (cycles < OP_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (done_o) begin
      abort_run("done_o to drop");
    end
    if (exp_err) begin
      exp_q.delete();
      exp_last_q.delete();
    end else begin
      build_expected(op, ar, ac, bc, scalar_i);
    end
    exp_beats = exp_q.size();
    op_i     = op;
    a_rows_i = ar;
    a_cols_i = ac;
    b_rows_i = br;
    b_cols_i = bc;
    start_i  = 1'b1;
    @(negedge clk);
    start_i   = 1'b0;
    cycles    = 0;
    seen_done = 1'b0;
    while (!seen_done && (cycles < OP_TIMEOUT)) begin
      if (bp_en) begin
        r              = rand_bits(1);
        stream_ready_i = r[0];
      end else begin
        stream_ready_i = 1'b1;
      end
      // Beat transfers on the coming rising edge
      if (stream_valid_o && stream_ready_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Unexpected stream beat %0d at %0t with no result pending",
                   stream_data_o, $time);
        end else begin
          check_elem(stream_data_o, exp_q.pop_front(), stream_last_col_o,
                     exp_last_q.pop_front());
        end
      end
      if (done_o) begin
        seen_done = 1'b1;
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    if (!seen_done) begin
      abort_run("done_o");
    end else begin
      check_flag("error_o", error_o, exp_err);
      if (exp_q.size() != 0) begin
        err_cnt++;
        $display("Stream ended at %0t with %0d result beats missing", $time, exp_q.size());
      end
      if (!exp_err) begin
        check_count("cycle_cnt_o", cycle_cnt_o, cnt_t'(exp_beats));
      end
    end
  endtask

  task automatic run_random(input op_code_t op, input int n);
    dim_t ar;
    dim_t ac;
    dim_t br;
    dim_t bc;
    for (int i = 0; i < n; i++) begin
      ar = rand_dim();
      ac = rand_dim();
      br = ar;
      bc = ac;
      if (op == OP_MAT_MUL) begin
        br = ac;
        bc = rand_dim();
      end
      load_operands();
      scalar_i = elem_t'(rand_bits(ELEM_W));
      run_op(op, ar, ac, br, bc, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    $display("Test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int base;
    rst_n          = 1'b0;
    start_i        = 1'b0;
    op_i           = OP_ADD;
    mat_a_i        = '0;
    mat_b_i        = '0;
    a_rows_i       = '0;
    a_cols_i       = '0;
    b_rows_i       = '0;
    b_cols_i       = '0;
    scalar_i       = '0;
    stream_ready_i = 1'b1;
    lfsr_q         = 16'd7676;
    bp_en          = 1'b0;
    err_cnt        = 0;
    chk_cnt        = 0;
    test_cnt       = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    base = err_cnt;
    run_random(OP_ADD, OPS_PER_TEST);
    report_test("element add", base);

    base = err_cnt;
    run_random(OP_SCALAR_MUL, OPS_PER_TEST);
    run_random(OP_TRANSPOSE, OPS_PER_TEST);
    report_test("scalar multiply and transpose", base);

    base = err_cnt;
    run_random(OP_MAT_MUL, OPS_PER_TEST);
    report_test("matrix multiply", base);

    // Illegal jobs, no beats expected
    base = err_cnt;
    run_op(OP_ADD, 3'd2, 3'd3, 3'd3, 3'd2, 1'b1);
    run_op(OP_MAT_MUL, 3'd2, 3'd3, 3'd2, 3'd3, 1'b1);
    run_op(OP_ADD, 3'd0, 3'd2, 3'd0, 3'd2, 1'b1);
    run_op(op_code_t'(3'd5), 3'd2, 3'd2, 3'd2, 3'd2, 1'b1);
    report_test("error cases", base);

    base  = err_cnt;
    bp_en = 1'b1;
    run_random(OP_ADD, 6);
    run_random(OP_SCALAR_MUL, 6);
    run_random(OP_TRANSPOSE, 6);
    run_random(OP_MAT_MUL, 6);
    bp_en = 1'b0;
    report_test("back-pressure", base);

    err_cnt = err_cnt + int'(matrix_alu_top_inst.matrix_alu_asserts_inst.assert_fails);
    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/matrix_alu_asserts.sv */
/* Matrix ALU protocol checks
   Stream hold rules and done behavior, bound to the top level */

`timescale 1ns/10ps
`default_nettype none

module matrix_alu_asserts (
  input wire                       clk,
  input wire                       rst_n,
  input wire                       done_o,
  input wire                       stream_ready_i,
  input wire                       stream_valid_o,
  input wire matrix_alu_pkg::acc_t stream_data_o,
  input wire                       stream_last_col_o
);

  // Number of failed checks
  int unsigned assert_fails = 0;

  // ------------------------------
  // Stream protocol
  // ------------------------------
  // Stalled beat keeps valid up
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stream_valid_o && !stream_ready_i |=> stream_valid_o)
    else begin
      assert_fails++;
      $error("stream_valid_o dropped before stream_ready_i");
    end

  // Payload frozen while stalled
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    stream_valid_o && !stream_ready_i |=> $stable(stream_data_o) && $stable(stream_last_col_o))
    else begin
      assert_fails++;
      $error("stream payload changed while stalled");
    end

  // No transfer once the job has finished
  a_no_beat_done: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> !(stream_valid_o && stream_ready_i))
    else begin
      assert_fails++;
      $error("stream beat while done_o is high");
    end

  a_done_reset: assert property (@(posedge clk) !rst_n |-> !done_o)
    else begin
      assert_fails++;
      $error("done_o high during reset");
    end

endmodule

bind matrix_alu_top matrix_alu_asserts matrix_alu_asserts_inst (
  .clk               (clk),
  .rst_n             (rst_n),
  .done_o            (done_o),
  .stream_ready_i    (stream_ready_i),
  .stream_valid_o    (stream_valid_o),
  .stream_data_o     (stream_data_o),
  .stream_last_col_o (stream_last_col_o)
);

`default_nettype wire

/* rtl/matrix_alu_top.sv */
/* Streaming matrix ALU top level
   Sequencer and element datapath joined by the request channel */

`timescale 1ns/10ps
`default_nettype none

module matrix_alu_top (
  input  wire                            clk,
  input  wire                            rst_n,
  // Job control
  input  wire                            start_i,
  input  wire matrix_alu_pkg::op_code_t  op_i,
  // Operands, stable from start until done
  input  wire matrix_alu_pkg::mat_flat_t mat_a_i,
  input  wire matrix_alu_pkg::mat_flat_t mat_b_i,
  input  wire matrix_alu_pkg::dim_t      a_rows_i,
  input  wire matrix_alu_pkg::dim_t      a_cols_i,
  input  wire matrix_alu_pkg::dim_t      b_rows_i,
  input  wire matrix_alu_pkg::dim_t      b_cols_i,
  input  wire matrix_alu_pkg::elem_t     scalar_i,
  // Status
  output logic                           done_o,
  output logic                           error_o,
  output matrix_alu_pkg::cnt_t           cycle_cnt_o,
  // Result stream
  input  wire                            stream_ready_i,
  output logic                           stream_valid_o,
  output matrix_alu_pkg::acc_t           stream_data_o,
  output logic                           stream_last_col_o
);

  // Datapath has drained
  logic dp_idle;

  alu_req_if req_if ();

  alu_seq_ctrl alu_seq_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .op_i        (op_i),
    .a_rows_i    (a_rows_i),
    .a_cols_i    (a_cols_i),
    .b_rows_i    (b_rows_i),
    .b_cols_i    (b_cols_i),
    .dp_idle_i   (dp_idle),
    .req         (req_if.seq),
    .done_o      (done_o),
    .error_o     (error_o),
    .cycle_cnt_o (cycle_cnt_o)
  );

  elem_datapath elem_datapath_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .req               (req_if.dp),
    .mat_a_i           (mat_a_i),
    .mat_b_i           (mat_b_i),
    .a_cols_i          (a_cols_i),
    .scalar_i          (scalar_i),
    .stream_ready_i    (stream_ready_i),
    .stream_valid_o    (stream_valid_o),
    .stream_data_o     (stream_data_o),
    .stream_last_col_o (stream_last_col_o),
    .dp_idle_o         (dp_idle)
  );

endmodule

`default_nettype wire

/* rtl/elem_datapath.sv */
/* Matrix ALU element datapath
   Fetches operands, computes one result element and drives the output stream */

`timescale 1ns/10ps
`default_nettype none

module elem_datapath (
  input  wire                            clk,
  input  wire                            rst_n,
  alu_req_if.dp                          req,
  input  wire matrix_alu_pkg::mat_flat_t mat_a_i,
  input  wire matrix_alu_pkg::mat_flat_t mat_b_i,
  input  wire matrix_alu_pkg::dim_t      a_cols_i,
  input  wire matrix_alu_pkg::elem_t     scalar_i,
  input  wire                            stream_ready_i,
  output logic                           stream_valid_o,
  output matrix_alu_pkg::acc_t           stream_data_o,
  output logic                           stream_last_col_o,
  output logic                           dp_idle_o
);
  import matrix_alu_pkg::*;

  // Compute stage phases
  typedef enum logic [2:0] {
    CS_IDLE,
    CS_FETCH,
    CS_MAC,
    CS_EXEC,
    CS_DONE
  } cs_state_t;

  cs_state_t cs;

  // Request held in the compute stage
  op_code_t  op_q;
  idx_t      row_q;
  idx_t      col_q;
  logic      last_col_q;
  // Inner-product index
  idx_t      k_q;
  idx_t      last_k;

  // Sign-extended operands and running sum
  acc_t      op_a;
  acc_t      op_b;
  acc_t      acc_q;
  // Finished element waiting for the output register
  acc_t      res_q;
  acc_t      exec_val;

  // Operands selected at request time
  elem_t     fetch_a;
  elem_t     fetch_b;

  logic      req_fire;
  logic      out_free;
  logic      out_load;

  // Element (r,c) of a flat matrix
  function automatic elem_t elem_at(input mat_flat_t m, input idx_t r, input idx_t c);
    return m[(int'(r) * MAX_DIM + int'(c)) * ELEM_W +: ELEM_W];
  endfunction

  assign req.req_ready = (cs == CS_IDLE);
  assign req_fire      = req.req_valid && req.req_ready;
  assign last_k        = idx_t'(a_cols_i - dim_t'(1));

  // ------------------------------
  // Operand select for one-shot ops
  // ------------------------------
  always_comb begin
    case (req.op)
      OP_SCALAR_MUL: begin
        fetch_a = elem_at(mat_a_i, req.row, req.col);
        fetch_b = scalar_i;
      end
      OP_TRANSPOSE: begin
        // Swapped indices
        fetch_a = elem_at(mat_a_i, req.col, req.row);
        fetch_b = '0;
      end
      default: begin
        fetch_a = elem_at(mat_a_i, req.row, req.col);
        fetch_b = elem_at(mat_b_i, req.row, req.col);
      end
    endcase
  end

  // Result of the exec phase
  always_comb begin
    case (op_q)
      OP_ADD:        exec_val = op_a + op_b;
      OP_SCALAR_MUL: exec_val = op_a * op_b;
      OP_MAT_MUL:    exec_val = acc_q;
      default:       exec_val = op_a;
    endcase
  end

  // ------------------------------
  // Compute stage control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs <= CS_IDLE;
    end else begin
      case (cs)
        CS_IDLE: begin
          // Matrix multiply loops, the rest has operands already
          if (req_fire) begin
            cs <= (req.op == OP_MAT_MUL) ? CS_FETCH : CS_EXEC;
          end
        end
        CS_FETCH: cs <= CS_MAC;
        CS_MAC:   cs <= (k_q == last_k) ? CS_EXEC : CS_FETCH;
        CS_EXEC:  cs <= CS_DONE;
        CS_DONE: begin
          // Stall here while the stream is blocked
          if (out_free) begin
            cs <= CS_IDLE;
          end
        end
        default: cs <= CS_IDLE;
      endcase
    end
  end

  // Compute stage payload
  always_ff @(posedge clk) begin
    case (cs)
      CS_IDLE: begin
        if (req_fire) begin
          op_q       <= req.op;
          row_q      <= req.row;
          col_q      <= req.col;
          last_col_q <= req.last_col;
          k_q        <= '0;
          acc_q      <= '0;
          op_a       <= acc_t'(fetch_a);
          op_b       <= acc_t'(fetch_b);
        end
      end
      CS_FETCH: begin
        // k-th pair A(row,k) and B(k,col)
        op_a <= acc_t'(elem_at(mat_a_i, row_q, k_q));
        op_b <= acc_t'(elem_at(mat_b_i, k_q, col_q));
      end
      CS_MAC: begin
        acc_q <= acc_q + op_a * op_b;
        k_q   <= k_q + idx_t'(1);
      end
      CS_EXEC: res_q <= exec_val;
    endcase
  end

  // ------------------------------
  // Output stream register
  // ------------------------------
  // Free when empty or draining this cycle
  assign out_free = !stream_valid_o || stream_ready_i;
  assign out_load = (cs == CS_DONE) && out_free;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stream_valid_o <= 1'b0;
    end else if (out_load) begin
      stream_valid_o <= 1'b1;
    end else if (stream_ready_i) begin
      stream_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      stream_data_o     <= res_q;
      stream_last_col_o <= last_col_q;
    end
  end

  // Nothing computing and nothing waiting on the stream
  assign dp_idle_o = (cs == CS_IDLE) && !stream_valid_o;

endmodule

`default_nettype wire

/* rtl/alu_seq_ctrl.sv */
/* Matrix ALU sequencer
   Checks shapes on start, walks the result in row-major order and reports done */

`timescale 1ns/10ps
`default_nettype none

module alu_seq_ctrl (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start_i,
  input  wire matrix_alu_pkg::op_code_t op_i,
  input  wire matrix_alu_pkg::dim_t     a_rows_i,
  input  wire matrix_alu_pkg::dim_t     a_cols_i,
  input  wire matrix_alu_pkg::dim_t     b_rows_i,
  input  wire matrix_alu_pkg::dim_t     b_cols_i,
  input  wire                           dp_idle_i,
  alu_req_if.seq                        req,
  output logic                          done_o,
  output logic                          error_o,
  output matrix_alu_pkg::cnt_t          cycle_cnt_o
);
  import matrix_alu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN,
    ST_DONE
  } seq_state_t;

  seq_state_t state;

  // Latched job
  op_code_t   op_q;
  dim_t       rows_lim;
  dim_t       cols_lim;
  // Current result position
  idx_t       row_q;
  idx_t       col_q;
  idx_t       last_row;
  idx_t       last_col_idx;

  // Decoded from the inputs at start
  logic       start_err;
  dim_t       res_rows;
  dim_t       res_cols;
  logic       req_fire;

  // Legal dimension is 1..MAX_DIM
  function automatic logic dim_ok(input dim_t d);
    return (d != '0) && (d <= dim_t'(MAX_DIM));
  endfunction

  // ------------------------------
  // Shape check and result size
  // ------------------------------
  always_comb begin
    start_err = !(dim_ok(a_rows_i) && dim_ok(a_cols_i) &&
                  dim_ok(b_rows_i) && dim_ok(b_cols_i));
    res_rows  = a_rows_i;
    res_cols  = a_cols_i;
    case (op_i)
      OP_ADD: begin
        // Both operands must have the same shape
        if ((a_rows_i != b_rows_i) || (a_cols_i != b_cols_i)) begin
          start_err = 1'b1;
        end
      end
      OP_SCALAR_MUL: begin
        // Result keeps the shape of A
      end
      OP_TRANSPOSE: begin
        res_rows = a_cols_i;
        res_cols = a_rows_i;
      end
      OP_MAT_MUL: begin
        // Inner dimensions have to agree
        res_cols = b_cols_i;
        if (a_cols_i != b_rows_i) begin
          start_err = 1'b1;
        end
      end
      default: start_err = 1'b1;
    endcase
  end

  // Limits are at least 1 once latched, so the index fits
  assign last_row     = idx_t'(rows_lim - dim_t'(1));
  assign last_col_idx = idx_t'(cols_lim - dim_t'(1));

  // ------------------------------
  // Request channel
  // ------------------------------
  assign req.req_valid = (state == ST_ISSUE);
  assign req.row       = row_q;
  assign req.col       = col_q;
  assign req.last_col  = (col_q == last_col_idx);
  assign req.op        = op_q;
  assign req_fire      = req.req_valid && req.req_ready;

  // ------------------------------
  // Operation FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      done_o      <= 1'b0;
      error_o     <= 1'b0;
      cycle_cnt_o <= '0;
      op_q        <= OP_ADD;
      rows_lim    <= '0;
      cols_lim    <= '0;
      row_q       <= '0;
      col_q       <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_i) begin
            error_o     <= start_err;
            cycle_cnt_o <= '0;
            op_q        <= op_i;
            rows_lim    <= res_rows;
            cols_lim    <= res_cols;
            row_q       <= '0;
            col_q       <= '0;
            // Illegal job skips straight to done, no beats
            state       <= start_err ? ST_DONE : ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          cycle_cnt_o <= cycle_cnt_o + cnt_t'(1);
          if (req_fire) begin
            // Row-major walk
            if (col_q == last_col_idx) begin
              col_q <= '0;
              if (row_q == last_row) begin
                state <= ST_DRAIN;
              end else begin
                row_q <= row_q + idx_t'(1);
              end
            end else begin
              col_q <= col_q + idx_t'(1);
            end
          end
        end
        ST_DRAIN: begin
          // Idle datapath means the last beat has left
          cycle_cnt_o <= cycle_cnt_o + cnt_t'(1);
          if (dp_idle_i) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!done_o) begin
            done_o      <= 1'b1;
            cycle_cnt_o <= cycle_cnt_o + cnt_t'(1);
          end else if (!start_i) begin
            // Hold done until start is released
            done_o <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/alu_req_if.sv */
/* Element request channel from the sequencer to the datapath
   One request per valid/ready transfer, fields held until accepted */

`timescale 1ns/10ps
`default_nettype none

interface alu_req_if;
  import matrix_alu_pkg::*;

  // Handshake
  logic     req_valid;
  logic     req_ready;
  // Result element position
  idx_t     row;
  idx_t     col;
  // Final column of the result row
  logic     last_col;
  // Operation of the running job
  op_code_t op;

  // Sequencer side
  modport seq (
    output req_valid,
    output row,
    output col,
    output last_col,
    output op,
    input  req_ready
  );

  // Datapath side
  modport dp (
    input  req_valid,
    input  row,
    input  col,
    input  last_col,
    input  op,
    output req_ready
  );

endinterface

`default_nettype wire

/* rtl/matrix_alu_pkg.sv */
/* Matrix ALU shared definitions
   Element, dimension, result and flat-matrix types with the operation codes */

`default_nettype none

package matrix_alu_pkg;

  // ------------------------------
  // Size constants
  // ------------------------------

  // Largest row or column count
  localparam int MAX_DIM = 4;
  // Matrix element and scalar width
  localparam int ELEM_W  = 8;
  // Full-precision stream result width
  localparam int ACC_W   = 32;
  // Dimension count holds 0..MAX_DIM
  localparam int DIM_W   = 3;
  // Row or column index holds 0..MAX_DIM-1
  localparam int IDX_W   = 2;
  // Cycle counter width
  localparam int CNT_W   = 32;
  // Flat matrix, all slots packed
  localparam int MAT_W   = MAX_DIM * MAX_DIM * ELEM_W;

  // ------------------------------
  // Types
  // ------------------------------

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic        [DIM_W-1:0]  dim_t;
  typedef logic        [IDX_W-1:0]  idx_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic        [CNT_W-1:0]  cnt_t;

  // Element (r,c) sits at slot r*MAX_DIM+c
  typedef logic [MAT_W-1:0] mat_flat_t;

  // Codes 4..7 are illegal
  typedef enum logic [2:0] {
    OP_ADD        = 3'd0,
    OP_SCALAR_MUL = 3'd1,
    OP_TRANSPOSE  = 3'd2,
    OP_MAT_MUL    = 3'd3
  } op_code_t;

endpackage

`default_nettype wire
